// File: arp_cache/arp_cache.sv
// ARP cache
// 16-entry direct-mapped IP to MAC table, indexed by a nibble XOR of the IP
// registered lookup, write port from the responder, bulk clear

`timescale 1ns/1ps

module arp_cache
    import arp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    cache_query_if.server        query,
    input  logic                 wr_valid,
    input  ip_t                  wr_ip,
    input  mac_t                 wr_mac,
    input  logic                 clear_cache
);

    localparam int ENTRIES = 2 ** CACHE_INDEX_W;
    localparam int NIBBLES = $bits(ip_t) / CACHE_INDEX_W;

    logic [ENTRIES-1:0] entry_valid;
    ip_t                entry_ip  [ENTRIES];
    mac_t               entry_mac [ENTRIES];

    cache_index_t wr_idx;
    cache_index_t rd_idx;

    function automatic cache_index_t index_of(input ip_t ip);
        cache_index_t idx;
        idx = '0;
        for (int i = 0; i < NIBBLES; i++) begin
            idx = idx ^ ip[i*CACHE_INDEX_W +: CACHE_INDEX_W];
        end
        return idx;
    endfunction

    assign wr_idx = index_of(wr_ip);
    assign rd_idx = index_of(query.req_ip);

    // valid bits and response strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid      <= '0;
            query.resp_valid <= 1'b0;
        end else begin
            query.resp_valid <= query.req_valid;
            // clear takes priority over a write in the same cycle
            if (clear_cache) begin
                entry_valid <= '0;
            end else if (wr_valid) begin
                entry_valid[wr_idx] <= 1'b1;
            end
        end
    end

    // table contents and lookup result
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            entry_ip[wr_idx]  <= wr_ip;
            entry_mac[wr_idx] <= wr_mac;
        end
        query.resp_hit <= entry_valid[rd_idx] && (entry_ip[rd_idx] == query.req_ip);
        query.resp_mac <= entry_mac[rd_idx];
    end

endmodule

// File: common/arp_frame_if.sv
// ARP frame request between internal blocks
// one strobe carries every field the outside framer needs

`timescale 1ns/1ps

interface arp_frame_if
    import arp_pkg::*;
();

    logic  valid;
    mac_t  dest_mac;
    oper_t oper;
    mac_t  tha;
    ip_t   tpa;

    modport src (output valid, dest_mac, oper, tha, tpa);
    modport dst (input valid, dest_mac, oper, tha, tpa);

endinterface

// File: common/arp_pkg.sv
// ARP engine shared definitions
// address types, protocol codes, cache geometry and resolver timing

package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] oper_t;
    typedef logic [15:0] eth_type_t;

    // protocol constants
    localparam eth_type_t ARP_ETH_TYPE  = 16'h0806;
    localparam oper_t     OPER_REQUEST  = 16'd1;
    localparam oper_t     OPER_REPLY    = 16'd2;
    localparam mac_t      BROADCAST_MAC = {48{1'b1}};
    localparam ip_t       BROADCAST_IP  = {32{1'b1}};

    // 16-entry direct-mapped cache
    localparam int CACHE_INDEX_W = 4;
    typedef logic [CACHE_INDEX_W-1:0] cache_index_t;

    // request retry timing, in cycles
    localparam int RETRY_COUNT     = 4;
    localparam int RETRY_INTERVAL  = 64;
    localparam int REQUEST_TIMEOUT = 256;
    localparam int TIMER_W         = 9;
    localparam int RETRY_W         = 3;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_QUERY,
        RS_WAIT,
        RS_DONE
    } resolve_state_t;

endpackage

// File: common/cache_query_if.sv
// ARP cache lookup channel
// request strobe with an IP, response one cycle later

`timescale 1ns/1ps

interface cache_query_if
    import arp_pkg::*;
();

    logic req_valid;
    ip_t  req_ip;
    logic resp_valid;
    logic resp_hit;
    mac_t resp_mac;

    modport client (output req_valid, req_ip, input resp_valid, resp_hit, resp_mac);
    modport server (input req_valid, req_ip, output resp_valid, resp_hit, resp_mac);

endinterface

// File: resolver/arp_resolver.sv
// ARP resolver
// resolves an IP to a MAC for the local client, with subnet routing,
// broadcast shortcuts, request retries and a final timeout

`timescale 1ns/1ps

module arp_resolver
    import arp_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          lookup_valid,
    input  ip_t           lookup_ip,
    input  ip_t           gateway_ip,
    input  ip_t           subnet_mask,
    output logic          lookup_busy,
    output logic          lookup_done,
    output logic          lookup_error,
    output mac_t          lookup_mac,
    cache_query_if.client query,
    arp_frame_if.src      req
);

    resolve_state_t       state;
    ip_t                  target;
    logic                 query_valid;
    logic                 frame_valid;
    logic [TIMER_W-1:0]   timer;
    logic [RETRY_W-1:0]   retry_cnt;

    logic in_subnet;
    logic is_bcast;
    logic accept;

    // no address bits differ from the gateway under the mask
    assign in_subnet = ((lookup_ip ^ gateway_ip) & subnet_mask) == '0;
    // limited broadcast, or all host bits set inside the subnet
    assign is_bcast  = (lookup_ip == BROADCAST_IP) ||
                       (in_subnet && ((lookup_ip | subnet_mask) == BROADCAST_IP));
    assign accept    = lookup_valid && (state == RS_IDLE);

    assign lookup_busy = (state != RS_IDLE);

    assign query.req_valid = query_valid;
    assign query.req_ip    = target;

    // broadcast request for the target
    assign req.valid    = frame_valid;
    assign req.dest_mac = BROADCAST_MAC;
    assign req.oper     = OPER_REQUEST;
    assign req.tha      = '0;
    assign req.tpa      = target;

    always_ff @(posedge clk) begin
        if (accept) begin
            target <= in_subnet ? lookup_ip : gateway_ip;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= RS_IDLE;
            query_valid  <= 1'b0;
            frame_valid  <= 1'b0;
            timer        <= '0;
            retry_cnt    <= '0;
            lookup_done  <= 1'b0;
            lookup_error <= 1'b0;
            lookup_mac   <= '0;
        end else begin
            frame_valid <= 1'b0;
            lookup_done <= 1'b0;
            case (state)
                RS_IDLE: begin
                    if (accept) begin
                        lookup_error <= 1'b0;
                        if (is_bcast) begin
                            lookup_mac  <= BROADCAST_MAC;
                            lookup_done <= 1'b1;
                            state       <= RS_DONE;
                        end else begin
                            query_valid <= 1'b1;
                            state       <= RS_QUERY;
                        end
                    end
                end
                RS_QUERY: begin
                    query_valid <= 1'b0;
                    if (query.resp_valid) begin
                        if (query.resp_hit) begin
                            lookup_mac  <= query.resp_mac;
                            lookup_done <= 1'b1;
                            state       <= RS_DONE;
                        end else begin
                            // miss, first request goes out and polling starts
                            frame_valid <= 1'b1;
                            query_valid <= 1'b1;
                            timer       <= TIMER_W'(RETRY_INTERVAL - 1);
                            retry_cnt   <= RETRY_W'(RETRY_COUNT - 1);
                            state       <= RS_WAIT;
                        end
                    end
                end
                RS_WAIT: begin
                    if (query.resp_valid && query.resp_hit) begin
                        query_valid <= 1'b0;
                        lookup_mac  <= query.resp_mac;
                        lookup_done <= 1'b1;
                        state       <= RS_DONE;
                    end else if (timer == '0) begin
                        if (retry_cnt != '0) begin
                            frame_valid <= 1'b1;
                            retry_cnt   <= retry_cnt - 1'b1;
                            // last frame gets the long timeout
                            timer <= (retry_cnt > 1) ? TIMER_W'(RETRY_INTERVAL - 1)
                                                     : TIMER_W'(REQUEST_TIMEOUT - 1);
                        end else begin
                            query_valid  <= 1'b0;
                            lookup_mac   <= '0;
                            lookup_error <= 1'b1;
                            lookup_done  <= 1'b1;
                            state        <= RS_DONE;
                        end
                    end else begin
                        timer <= timer - 1'b1;
                    end
                end
                RS_DONE: begin
                    state <= RS_IDLE;
                end
                default: begin
                    state <= RS_IDLE;
                end
            endcase
        end
    end

    // done is only ever raised on the way out of a lookup
    assert property (@(posedge clk) disable iff (rst) !(lookup_done && state == RS_IDLE));

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the ARP engine testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert --top-module arp_tb -f sim.f -o arp_sim \
    && ./obj_dir/arp_sim; } > sim.log 2>&1
grep -qx "Finished with no errors" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// File: sim.f
+incdir+tb
common/arp_pkg.sv
common/arp_frame_if.sv
common/cache_query_if.sv
arp_cache/arp_cache.sv
src/arp_responder.sv
resolver/arp_resolver.sv
src/arp_tx_arbiter.sv
src/arp_top.sv
tb/arp_tb.sv

// File: src/arp_responder.sv
// ARP responder
// learns the sender of every received ARP frame and answers requests
// for the local IP with a reply frame

`timescale 1ns/1ps

module arp_responder
    import arp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rx_valid,
    input  mac_t      rx_src_mac,
    input  eth_type_t rx_eth_type,
    input  oper_t     rx_oper,
    input  mac_t      rx_sha,
    input  ip_t       rx_spa,
    input  ip_t       rx_tpa,
    input  ip_t       local_ip,
    output logic      wr_valid,
    output ip_t       wr_ip,
    output mac_t      wr_mac,
    arp_frame_if.src  reply
);

    logic is_arp;
    logic is_local_req;

    assign is_arp       = rx_valid && (rx_eth_type == ARP_ETH_TYPE);
    assign is_local_req = is_arp && (rx_oper == OPER_REQUEST) && (rx_tpa == local_ip);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid    <= 1'b0;
            reply.valid <= 1'b0;
        end else begin
            wr_valid    <= is_arp;
            reply.valid <= is_local_req;
        end
    end

    // sender pair for the cache, reply addressed back to the sender
    always_ff @(posedge clk) begin
        wr_ip          <= rx_spa;
        wr_mac         <= rx_sha;
        reply.dest_mac <= rx_src_mac;
        reply.oper     <= OPER_REPLY;
        reply.tha      <= rx_sha;
        reply.tpa      <= rx_spa;
    end

    // frames arrive at most every other cycle
    assert property (@(posedge clk) disable iff (rst) rx_valid |=> !rx_valid);

endmodule

// File: src/arp_top.sv
// ARP engine top level
// responder, cache, resolver and transmit arbiter on plain ports

`timescale 1ns/1ps

module arp_top
    import arp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    // received frame fields
    input  logic      rx_valid,
    input  mac_t      rx_src_mac,
    input  eth_type_t rx_eth_type,
    input  oper_t     rx_oper,
    input  mac_t      rx_sha,
    input  ip_t       rx_spa,
    input  ip_t       rx_tpa,
    // transmitted frame fields
    output logic      tx_valid,
    output mac_t      tx_dest_mac,
    output oper_t     tx_oper,
    output mac_t      tx_tha,
    output ip_t       tx_tpa,
    // client lookups
    input  logic      lookup_valid,
    input  ip_t       lookup_ip,
    output logic      lookup_busy,
    output logic      lookup_done,
    output logic      lookup_error,
    output mac_t      lookup_mac,
    // configuration
    input  ip_t       local_ip,
    input  ip_t       gateway_ip,
    input  ip_t       subnet_mask,
    input  logic      clear_cache
);

    logic wr_valid;
    ip_t  wr_ip;
    mac_t wr_mac;

    arp_frame_if   reply_frame ();
    arp_frame_if   req_frame ();
    cache_query_if cache_query ();

    arp_responder responder (
        .clk         (clk),
        .rst         (rst),
        .rx_valid    (rx_valid),
        .rx_src_mac  (rx_src_mac),
        .rx_eth_type (rx_eth_type),
        .rx_oper     (rx_oper),
        .rx_sha      (rx_sha),
        .rx_spa      (rx_spa),
        .rx_tpa      (rx_tpa),
        .local_ip    (local_ip),
        .wr_valid    (wr_valid),
        .wr_ip       (wr_ip),
        .wr_mac      (wr_mac),
        .reply       (reply_frame.src)
    );

    arp_cache cache (
        .clk         (clk),
        .rst         (rst),
        .query       (cache_query.server),
        .wr_valid    (wr_valid),
        .wr_ip       (wr_ip),
        .wr_mac      (wr_mac),
        .clear_cache (clear_cache)
    );

    arp_resolver resolver (
        .clk          (clk),
        .rst          (rst),
        .lookup_valid (lookup_valid),
        .lookup_ip    (lookup_ip),
        .gateway_ip   (gateway_ip),
        .subnet_mask  (subnet_mask),
        .lookup_busy  (lookup_busy),
        .lookup_done  (lookup_done),
        .lookup_error (lookup_error),
        .lookup_mac   (lookup_mac),
        .query        (cache_query.client),
        .req          (req_frame.src)
    );

    arp_tx_arbiter tx_arbiter (
        .clk         (clk),
        .rst         (rst),
        .reply       (reply_frame.dst),
        .req         (req_frame.dst),
        .tx_valid    (tx_valid),
        .tx_dest_mac (tx_dest_mac),
        .tx_oper     (tx_oper),
        .tx_tha      (tx_tha),
        .tx_tpa      (tx_tpa)
    );

endmodule

// File: src/arp_tx_arbiter.sv
// ARP transmit arbiter
// merges reply and request frames onto one registered transmit port,
// replies win and a losing request waits in a one-entry slot

`timescale 1ns/1ps

module arp_tx_arbiter
    import arp_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    arp_frame_if.dst reply,
    arp_frame_if.dst req,
    output logic     tx_valid,
    output mac_t     tx_dest_mac,
    output oper_t    tx_oper,
    output mac_t     tx_tha,
    output ip_t      tx_tpa
);

    logic  pend_valid;
    mac_t  pend_dest_mac;
    oper_t pend_oper;
    mac_t  pend_tha;
    ip_t   pend_tpa;

    always_ff @(posedge clk) begin
        if (rst) begin
            tx_valid   <= 1'b0;
            pend_valid <= 1'b0;
        end else begin
            tx_valid <= reply.valid || pend_valid || req.valid;
            // slot fills on a collision and drains in the first free cycle
            pend_valid <= reply.valid ? (pend_valid || req.valid) : 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reply.valid) begin
            tx_dest_mac <= reply.dest_mac;
            tx_oper     <= reply.oper;
            tx_tha      <= reply.tha;
            tx_tpa      <= reply.tpa;
        end else if (pend_valid) begin
            tx_dest_mac <= pend_dest_mac;
            tx_oper     <= pend_oper;
            tx_tha      <= pend_tha;
            tx_tpa      <= pend_tpa;
        end else if (req.valid) begin
            tx_dest_mac <= req.dest_mac;
            tx_oper     <= req.oper;
            tx_tha      <= req.tha;
            tx_tpa      <= req.tpa;
        end
        if (reply.valid && req.valid) begin
            pend_dest_mac <= req.dest_mac;
            pend_oper     <= req.oper;
            pend_tha      <= req.tha;
            pend_tpa      <= req.tpa;
        end
    end

    // resolver frames are spaced far enough apart for the slot to drain
    assert property (@(posedge clk) disable iff (rst) req.valid |-> !pend_valid);

endmodule

// File: tb/arp_tb_model.svh
// ARP testbench reference model
// cache contents, routing rule and the frames the engine should send

`ifndef ARP_TB_MODEL_SVH
`define ARP_TB_MODEL_SVH

logic model_valid [16];
ip_t  model_ip    [16];
mac_t model_mac   [16];

// cache slot is the XOR of all eight nibbles
function automatic logic [3:0] slot_of(input ip_t ip);
    logic [3:0] s;
    s = 4'h0;
    for (int i = 0; i < 8; i++) begin
        s = s ^ ip[i*4 +: 4];
    end
    return s;
endfunction

function automatic void model_learn(input ip_t ip, input mac_t mac);
    model_valid[slot_of(ip)] = 1'b1;
    model_ip[slot_of(ip)]    = ip;
    model_mac[slot_of(ip)]   = mac;
endfunction

function automatic void model_clear();
    for (int i = 0; i < 16; i++) begin
        model_valid[i] = 1'b0;
    end
endfunction

// same network prefix as the local address
function automatic logic on_subnet(input ip_t ip);
    return (ip & subnet_mask) == (local_ip & subnet_mask);
endfunction

function automatic logic is_broadcast(input ip_t ip);
    return (ip == BROADCAST_IP) || (on_subnet(ip) && ((ip & ~subnet_mask) == ~subnet_mask));
endfunction

function automatic ip_t route_of(input ip_t ip);
    return on_subnet(ip) ? ip : gateway_ip;
endfunction

// returns 1 when the lookup should succeed
function automatic logic model_resolve(input ip_t ip, output mac_t mac);
    logic [3:0] s;
    s = slot_of(route_of(ip));
    mac = '0;
    if (is_broadcast(ip)) begin
        mac = BROADCAST_MAC;
        return 1'b1;
    end
    if (model_valid[s] && model_ip[s] == route_of(ip)) begin
        mac = model_mac[s];
        return 1'b1;
    end
    return 1'b0;
endfunction

function automatic frame_t reply_frame_of(input mac_t src, input mac_t sha, input ip_t spa);
    return {src, OPER_REPLY, sha, spa};
endfunction

function automatic frame_t request_frame_of(input ip_t ip);
    return {BROADCAST_MAC, OPER_REQUEST, 48'h0, route_of(ip)};
endfunction

`endif

// File: tb/arp_tb.sv
// ARP engine testbench
// random frames and lookups from a fixed seed, checked against a reference model

`timescale 1ns/1ps

module arp_tb
    import arp_pkg::*;
();

    localparam int TIMEOUT = 2000;

    // dest_mac, oper, tha, tpa
    typedef logic [143:0] frame_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      rx_valid;
    mac_t      rx_src_mac;
    eth_type_t rx_eth_type;
    oper_t     rx_oper;
    mac_t      rx_sha;
    ip_t       rx_spa;
    ip_t       rx_tpa;
    logic      tx_valid;
    mac_t      tx_dest_mac;
    oper_t     tx_oper;
    mac_t      tx_tha;
    ip_t       tx_tpa;
    logic      lookup_valid;
    ip_t       lookup_ip;
    logic      lookup_busy;
    logic      lookup_done;
    logic      lookup_error;
    mac_t      lookup_mac;
    ip_t       local_ip;
    ip_t       gateway_ip;
    ip_t       subnet_mask;
    logic      clear_cache;

    logic [31:0] rng_state;
    frame_t      tx_q [$];

    `include "arp_tb_model.svh"

    arp_top UUT (.*);

    always #5 clk = ~clk;

    // transmitted frames, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && tx_valid) begin
            tx_q.push_back({tx_dest_mac, tx_oper, tx_tha, tx_tpa});
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input frame_t got, input frame_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic mac_t rand_mac();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[15:0], lo};
    endfunction

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    // one rx strobe, then a quiet cycle
    task automatic send_frame(input mac_t src, input eth_type_t et, input oper_t op,
                              input mac_t sha, input ip_t spa, input ip_t tpa);
        rx_valid    = 1'b1;
        rx_src_mac  = src;
        rx_eth_type = et;
        rx_oper     = op;
        rx_sha      = sha;
        rx_spa      = spa;
        rx_tpa      = tpa;
        tick();
        rx_valid = 1'b0;
        tick();
        if (et == ARP_ETH_TYPE) begin
            model_learn(spa, sha);
        end
    endtask

    task automatic wait_tx_count(input int n);
        int cycles;
        cycles = 0;
        while (tx_q.size() < n) begin
            if (cycles == TIMEOUT) begin
                fail_run($sformatf("timed out waiting for %0d transmitted frames", n));
            end
            tick();
            cycles++;
        end
    endtask

    task automatic start_lookup(input ip_t ip);
        int cycles;
        cycles = 0;
        while (lookup_busy) begin
            if (cycles == TIMEOUT) begin
                fail_run("timed out waiting for the resolver to become idle");
            end
            tick();
            cycles++;
        end
        lookup_ip    = ip;
        lookup_valid = 1'b1;
        tick();
        lookup_valid = 1'b0;
        // an accepted lookup holds the resolver busy
        check_value("lookup_busy", 144'(lookup_busy), 144'(1));
    endtask

    task automatic finish_lookup(input ip_t ip);
        int   cycles;
        mac_t exp_mac;
        logic hit;
        cycles = 0;
        while (!lookup_done) begin
            if (cycles == TIMEOUT) begin
                fail_run("timed out waiting for lookup_done");
            end
            tick();
            cycles++;
        end
        hit = model_resolve(ip, exp_mac);
        check_value("lookup_mac", 144'(lookup_mac), 144'(exp_mac));
        check_value("lookup_error", 144'(lookup_error), 144'(!hit));
        tick();
        check_value("lookup_busy", 144'(lookup_busy), 144'(0));
    endtask

    task automatic run_lookup(input ip_t ip);
        start_lookup(ip);
        finish_lookup(ip);
    endtask

    initial begin
        mac_t        src;
        mac_t        sha;
        ip_t         spa;
        ip_t         ip;
        logic [31:0] r;
        rng_state    = 32'h7366_98cc;
        rst          = 1'b1;
        rx_valid     = 1'b0;
        rx_src_mac   = '0;
        rx_eth_type  = '0;
        rx_oper      = '0;
        rx_sha       = '0;
        rx_spa       = '0;
        rx_tpa       = '0;
        lookup_valid = 1'b0;
        lookup_ip    = '0;
        local_ip     = 32'hC0A8_0164;
        gateway_ip   = 32'hC0A8_0101;
        subnet_mask  = 32'hFFFF_FF00;
        clear_cache  = 1'b0;
        model_clear();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        // replies for local requests, silence for other targets and non-ARP frames
        for (int i = 0; i < 8; i++) begin
            src = rand_mac();
            sha = rand_mac();
            r   = next_rand();
            spa = (local_ip & subnet_mask) | {24'h0, r[7:0]};
            send_frame(src, ARP_ETH_TYPE, OPER_REQUEST, sha, spa, local_ip);
            wait_tx_count(1);
            check_value("tx frame", tx_q.pop_front(), reply_frame_of(src, sha, spa));
            send_frame(src, ARP_ETH_TYPE, OPER_REQUEST, sha, spa,
                       local_ip ^ {24'h0, r[15:8] | 8'h01});
            send_frame(src, 16'h0800, OPER_REQUEST, sha, spa, local_ip);
            tick();
            tick();
            check_value("tx frame count", 144'(tx_q.size()), 144'(0));
        end

        // limited and subnet broadcast
        run_lookup(BROADCAST_IP);
        run_lookup(local_ip | ~subnet_mask);

        // learn random senders, then look up everything the model holds
        for (int i = 0; i < 12; i++) begin
            r   = next_rand();
            spa = (local_ip & subnet_mask) | {24'h0, r[7:0]};
            send_frame(rand_mac(), ARP_ETH_TYPE, r[8] ? OPER_REPLY : OPER_REQUEST,
                       rand_mac(), spa, next_rand());
        end
        for (int i = 0; i < 16; i++) begin
            if (model_valid[i]) begin
                run_lookup(model_ip[i]);
            end
        end

        // off-subnet address goes through the gateway
        send_frame(rand_mac(), ARP_ETH_TYPE, OPER_REPLY, rand_mac(), gateway_ip, local_ip);
        r  = next_rand();
        ip = {8'h0A, r[23:0]};
        run_lookup(ip);

        // cleared cache turns a known address into a miss with full retries
        clear_cache = 1'b1;
        tick();
        clear_cache = 1'b0;
        model_clear();
        tx_q.delete();
        start_lookup(gateway_ip);
        // a second strobe while busy changes nothing
        lookup_ip    = BROADCAST_IP;
        lookup_valid = 1'b1;
        tick();
        lookup_valid = 1'b0;
        finish_lookup(gateway_ip);
        check_value("request frame count", 144'(tx_q.size()), 144'(RETRY_COUNT));
        while (tx_q.size() > 0) begin
            check_value("tx frame", tx_q.pop_front(), request_frame_of(gateway_ip));
        end

        // answer arrives after the first request
        r  = next_rand();
        ip = (local_ip & subnet_mask) | ({25'h0, r[6:0]} + 32'd1);
        start_lookup(ip);
        wait_tx_count(1);
        check_value("tx frame", tx_q.pop_front(), request_frame_of(ip));
        send_frame(rand_mac(), ARP_ETH_TYPE, OPER_REPLY, rand_mac(), ip, local_ip);
        finish_lookup(ip);

        tick();
        $display("Finished with no errors");
        $finish;
    end

endmodule
